/* mcu_ctrl.sv */
// Command handshake FSM, burst address and size setup,
// burst start pulses and completion tracking

`timescale 1ns/1ns
`include "mcu_macros.svh"

module mcu_ctrl (
  input  logic                  clk,
  input  logic                  ctrl_rstart,
  input  logic                  cmd_req_i,
  input  logic                  cmd_store_i,
  input  mcu_pkg::sew_e         cmd_sew_i,
  input  logic [`MCU_VL_W-1:0]  cmd_vl_i,
  input  logic [`MCU_BUS_W-1:0] cmd_base_addr_i,
  input  logic                  rd_done_i,
  input  logic                  wr_done_i,
  input  logic                  ld_done_i,
  input  logic                  st_done_i,
  output logic                  cmd_ack_o,
  output logic [`MCU_BUS_W-1:0] rd_addr_o,
  output logic [`MCU_BUS_W-1:0] rd_xfer_size_o,
  output logic                  rd_start_o,
  output logic [`MCU_BUS_W-1:0] wr_addr_o,
  output logic [`MCU_BUS_W-1:0] wr_xfer_size_o,
  output logic                  wr_start_o,
  output logic                  ld_start_o,
  output logic                  st_start_o,
  output mcu_pkg::sew_e         sew_o,
  output logic [`MCU_VL_W-1:0]  vl_o
);
  import mcu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_BUSY,
    S_ACK
  } state_e;

  state_e                state_q;
  logic                  store_q;
  logic [`MCU_BUS_W-1:0] addr_q;
  logic [`MCU_BUS_W-1:0] size_q;
  logic                  bus_done_q;
  logic                  path_done_q;
  logic                  bus_done;
  logic                  path_done;
  logic                  accept;

  assign accept    = (state_q == S_IDLE) && cmd_req_i;
  // Either side may finish first, so keep both flags
  assign bus_done  = bus_done_q || (store_q ? wr_done_i : rd_done_i);
  assign path_done = path_done_q || (store_q ? st_done_i : ld_done_i);

  assign rd_addr_o      = addr_q;
  assign wr_addr_o      = addr_q;
  assign rd_xfer_size_o = size_q;
  assign wr_xfer_size_o = size_q;
  // Path start travels with the burst start
  assign ld_start_o     = rd_start_o;
  assign st_start_o     = wr_start_o;

  ////////////////////////////////////////////////////////////
  // Command capture
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (accept) begin
      store_q <= cmd_store_i;
      sew_o   <= cmd_sew_i;
      vl_o    <= cmd_vl_i;
      addr_q  <= cmd_base_addr_i;
      size_q  <= `MCU_BUS_W'({words_of(cmd_vl_i, cmd_sew_i), 2'b00});
    end
  end

  ////////////////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (ctrl_rstart) begin
      state_q     <= S_IDLE;
      cmd_ack_o   <= 1'b0;
      rd_start_o  <= 1'b0;
      wr_start_o  <= 1'b0;
      bus_done_q  <= 1'b0;
      path_done_q <= 1'b0;
    end else begin
      rd_start_o <= accept && !cmd_store_i;
      wr_start_o <= accept && cmd_store_i;
      case (state_q)
        S_IDLE: begin
          if (cmd_req_i) begin
            state_q     <= S_BUSY;
            bus_done_q  <= 1'b0;
            path_done_q <= 1'b0;
          end
        end
        S_BUSY: begin
          bus_done_q  <= bus_done;
          path_done_q <= path_done;
          if (bus_done && path_done) begin
            state_q   <= S_ACK;
            cmd_ack_o <= 1'b1;
          end
        end
        S_ACK: begin
          // Hold ack until the scheduler drops its request
          if (!cmd_req_i) begin
            state_q   <= S_IDLE;
            cmd_ack_o <= 1'b0;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  a_start_pulse: assert property (@(posedge clk) disable iff (ctrl_rstart)
    (rd_start_o || wr_start_o) |=> !(rd_start_o || wr_start_o));

  a_ack_with_req: assert property (@(posedge clk) disable iff (ctrl_rstart)
    $rose(cmd_ack_o) |-> cmd_req_i);

endmodule

/* mcu_load_path.sv */
// Load path: unpacks read stream words into four-lane
// element groups with lane mask and last flag

`timescale 1ns/1ns
`include "mcu_macros.svh"

module mcu_load_path (
  input  logic                              clk,
  input  logic                              ctrl_rstart,
  input  logic                              ld_start_i,
  input  mcu_pkg::sew_e                     sew_i,
  input  logic [`MCU_VL_W-1:0]              vl_i,
  input  logic [`MCU_BUS_W-1:0]             rd_tdata_i,
  input  logic                              rd_tvalid_i,
  input  logic                              rd_tlast_i,
  input  logic                              lane_ld_ready_i,
  output logic                              ld_done_o,
  output logic                              rd_tready_o,
  output logic [`MCU_LANES*`MCU_BUS_W-1:0]  lane_ld_data_o,
  output logic [`MCU_LANES-1:0]             lane_ld_mask_o,
  output logic                              lane_ld_valid_o,
  output logic                              lane_ld_last_o
);
  import mcu_pkg::*;

  localparam int CNT_W = `MCU_VL_W + 1;

  logic                  active_q;
  logic [CNT_W-1:0]      elem_q;
  logic [CNT_W-1:0]      elem_nxt;
  logic [CNT_W-1:0]      grp_base;
  logic [CNT_W-1:0]      vl_ext;
  logic [1:0]            slot;
  logic [2:0]            epw;
  logic                  rd_fire;
  logic                  ld_fire;
  logic                  grp_end;
  bus_word_u             word;
  logic [`MCU_BUS_W-1:0] grp_q [`MCU_LANES];

  // Elements per bus word
  always_comb begin
    case (sew_i)
      SEW8:    epw = 3'd4;
      SEW16:   epw = 3'd2;
      default: epw = 3'd1;
    endcase
  end

  // Words never straddle a group, so the slot is the low count bits
  assign slot     = elem_q[1:0];
  assign grp_base = {elem_q[CNT_W-1:2], 2'b00};
  assign vl_ext   = CNT_W'(vl_i);
  assign elem_nxt = elem_q + CNT_W'(epw);
  assign grp_end  = (elem_nxt[1:0] == 2'b00) || (elem_nxt >= vl_ext);

  assign word        = rd_tdata_i;
  assign rd_tready_o = active_q && !lane_ld_valid_o;
  assign rd_fire     = rd_tvalid_i && rd_tready_o;
  assign ld_fire     = lane_ld_valid_o && lane_ld_ready_i;

  ////////////////////////////////////////////////////////////
  // Element unpacking, lowest byte is the lowest element
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      case (sew_i)
        SEW8: begin
          for (int k = 0; k < `MCU_BUS_W / 8; k++) begin
            grp_q[k] <= `MCU_BUS_W'(word.b[k]);
          end
        end
        SEW16: begin
          grp_q[slot]        <= `MCU_BUS_W'(word.h[0]);
          grp_q[slot + 2'd1] <= `MCU_BUS_W'(word.h[1]);
        end
        default: grp_q[slot] <= word.w;
      endcase
    end
  end

  // Group presentation and completion
  always_ff @(posedge clk) begin
    if (ctrl_rstart) begin
      active_q        <= 1'b0;
      elem_q          <= '0;
      lane_ld_valid_o <= 1'b0;
      lane_ld_last_o  <= 1'b0;
      lane_ld_mask_o  <= '0;
      ld_done_o       <= 1'b0;
    end else begin
      ld_done_o <= 1'b0;
      if (ld_start_i) begin
        active_q <= 1'b1;
        elem_q   <= '0;
      end else if (rd_fire) begin
        elem_q <= elem_nxt;
        if (grp_end) begin
          lane_ld_valid_o <= 1'b1;
          lane_ld_last_o  <= elem_nxt >= vl_ext;
          for (int k = 0; k < `MCU_LANES; k++) begin
            lane_ld_mask_o[k] <= (grp_base + CNT_W'(k)) < vl_ext;
          end
        end
      end
      if (ld_fire) begin
        lane_ld_valid_o <= 1'b0;
        if (lane_ld_last_o) begin
          active_q  <= 1'b0;
          ld_done_o <= 1'b1;
        end
      end
    end
  end

  // Padding lanes read as zero
  always_comb begin
    for (int k = 0; k < `MCU_LANES; k++) begin
      lane_ld_data_o[k*`MCU_BUS_W +: `MCU_BUS_W] = lane_ld_mask_o[k] ? grp_q[k] : '0;
    end
  end

  a_tlast_final: assert property (@(posedge clk) disable iff (ctrl_rstart)
    rd_fire |-> (rd_tlast_i == (elem_nxt >= vl_ext)));

endmodule

/* mcu_macros.svh */
// Shared sizing defines for the vector memory subsystem
// Lane count, AXI stream width and vector-length field width

`ifndef MCU_MACROS_SVH
`define MCU_MACROS_SVH

// Number of vector lanes served per element group
`define MCU_LANES 4

// AXI stream data width, also used for addresses and burst sizes
`define MCU_BUS_W 32

// Vector-length field, up to 256 elements
`define MCU_VL_W 9

`endif

/* mcu_patterns.hex */
// Columns, all hex: op (0 load, 1 store), sew (0 = 8, 1 = 16, 2 = 32),
// vl, base byte address, expected burst size in bytes
0 0 010 00001000 00000010
0 0 007 00002004 00000008
0 1 009 00003000 00000014
0 2 005 00004010 00000014
1 0 00d 00005000 00000010
1 1 006 00006008 0000000c
1 2 003 00007000 0000000c
0 0 001 00000080 00000004
1 1 001 00000100 00000004
0 1 020 00009000 00000040
1 0 028 0000a000 00000028
0 2 002 0000b000 00000008
1 2 008 0000c000 00000020
0 0 100 0000d000 00000100
1 1 011 0000e000 00000024

/* mcu_pkg.sv */
// Package with the SEW type, the bus word views
// and the element size and word count helpers

`include "mcu_macros.svh"

package mcu_pkg;

  // Selected element width
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  // One bus word, viewed by bytes, halfwords or as a plain word
  typedef union packed {
    logic [`MCU_BUS_W/8-1:0][7:0]   b;
    logic [`MCU_BUS_W/16-1:0][15:0] h;
    logic [`MCU_BUS_W-1:0]          w;
  } bus_word_u;

  // Element size in bytes
  function automatic logic [2:0] bytes_of(input sew_e sew);
    case (sew)
      SEW8:    return 3'd1;
      SEW16:   return 3'd2;
      default: return 3'd4;
    endcase
  endfunction

  // Bus words needed for vl elements, rounded up to whole words
  function automatic logic [`MCU_VL_W-1:0] words_of(input logic [`MCU_VL_W-1:0] vl,
                                                     input sew_e                sew);
    logic [`MCU_VL_W+2:0] nbytes;
    nbytes = vl * bytes_of(sew);
    return `MCU_VL_W'((nbytes + 3) >> 2);
  endfunction

endpackage

/* mcu_store_path.sv */
// Store path: packs four-lane element groups into
// write stream words with zero padding past vl

`timescale 1ns/1ns
`include "mcu_macros.svh"

module mcu_store_path (
  input  logic                              clk,
  input  logic                              ctrl_rstart,
  input  logic                              st_start_i,
  input  mcu_pkg::sew_e                     sew_i,
  input  logic [`MCU_VL_W-1:0]              vl_i,
  input  logic [`MCU_LANES*`MCU_BUS_W-1:0]  lane_st_data_i,
  input  logic                              lane_st_valid_i,
  input  logic                              wr_tready_i,
  output logic                              st_done_o,
  output logic                              lane_st_ready_o,
  output logic [`MCU_BUS_W-1:0]             wr_tdata_o,
  output logic                              wr_tvalid_o
);
  import mcu_pkg::*;

  localparam int CNT_W = `MCU_VL_W + 1;

  logic                  active_q;
  logic                  pend_q;
  logic [1:0]            sub_q;
  logic [1:0]            last_sub;
  logic [`MCU_VL_W-1:0]  wcnt_q;
  logic [`MCU_VL_W-1:0]  total_w;
  logic [CNT_W-1:0]      gbase_q;
  logic [CNT_W-1:0]      vl_ext;
  logic                  lane_fire;
  logic                  wr_fire;
  bus_word_u             word;
  logic [`MCU_BUS_W-1:0] grp_q [`MCU_LANES];

  // Last word index within one group
  always_comb begin
    case (sew_i)
      SEW8:    last_sub = 2'd0;
      SEW16:   last_sub = 2'd1;
      default: last_sub = 2'd3;
    endcase
  end

  assign total_w         = words_of(vl_i, sew_i);
  assign vl_ext          = CNT_W'(vl_i);
  assign lane_st_ready_o = active_q && !pend_q;
  assign wr_tvalid_o     = pend_q;
  assign lane_fire       = lane_st_valid_i && lane_st_ready_o;
  assign wr_fire         = wr_tvalid_o && wr_tready_i;

  ////////////////////////////////////////////////////////////
  // Pack register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (lane_fire) begin
      for (int k = 0; k < `MCU_LANES; k++) begin
        grp_q[k] <= ((gbase_q + CNT_W'(k)) < vl_ext) ?
                    lane_st_data_i[k*`MCU_BUS_W +: `MCU_BUS_W] : '0;
      end
    end
  end

  // Word view of the current sub-word
  always_comb begin
    word = '0;
    case (sew_i)
      SEW8: begin
        for (int k = 0; k < `MCU_BUS_W / 8; k++) begin
          word.b[k] = grp_q[k][7:0];
        end
      end
      SEW16: begin
        for (int k = 0; k < `MCU_BUS_W / 16; k++) begin
          word.h[k] = grp_q[2 * sub_q + k][15:0];
        end
      end
      default: word.w = grp_q[sub_q];
    endcase
  end

  assign wr_tdata_o = word.w;

  // Group and word sequencing
  always_ff @(posedge clk) begin
    if (ctrl_rstart) begin
      active_q  <= 1'b0;
      pend_q    <= 1'b0;
      sub_q     <= 2'd0;
      wcnt_q    <= '0;
      gbase_q   <= '0;
      st_done_o <= 1'b0;
    end else begin
      st_done_o <= 1'b0;
      if (st_start_i) begin
        active_q <= 1'b1;
        wcnt_q   <= '0;
        gbase_q  <= '0;
      end
      if (lane_fire) begin
        pend_q  <= 1'b1;
        sub_q   <= 2'd0;
        gbase_q <= gbase_q + CNT_W'(`MCU_LANES);
      end
      if (wr_fire) begin
        wcnt_q <= wcnt_q + 1'b1;
        if (wcnt_q + 1'b1 == total_w) begin
          // Final word of the burst
          pend_q    <= 1'b0;
          active_q  <= 1'b0;
          st_done_o <= 1'b1;
        end else if (sub_q == last_sub) begin
          pend_q <= 1'b0;
        end else begin
          sub_q <= sub_q + 2'd1;
        end
      end
    end
  end

  a_wr_stable: assert property (@(posedge clk) disable iff (ctrl_rstart)
    (wr_tvalid_o && !wr_tready_i) |=> (wr_tvalid_o && $stable(wr_tdata_o)));

endmodule

/* mem_subsys.sv */
// Vector memory subsystem top: controller, load path
// and store path

`timescale 1ns/1ns
`include "mcu_macros.svh"

module mem_subsys (
  input  logic                              clk,
  input  logic                              ctrl_rstart,
  // Scheduler command
  input  logic                              cmd_req_i,
  input  logic                              cmd_store_i,
  input  mcu_pkg::sew_e                     cmd_sew_i,
  input  logic [`MCU_VL_W-1:0]              cmd_vl_i,
  input  logic [`MCU_BUS_W-1:0]             cmd_base_addr_i,
  output logic                              cmd_ack_o,
  // AXI control, read channel
  output logic [`MCU_BUS_W-1:0]             rd_addr_o,
  output logic [`MCU_BUS_W-1:0]             rd_xfer_size_o,
  output logic                              rd_start_o,
  input  logic                              rd_done_i,
  input  logic [`MCU_BUS_W-1:0]             rd_tdata_i,
  input  logic                              rd_tvalid_i,
  input  logic                              rd_tlast_i,
  output logic                              rd_tready_o,
  // AXI control, write channel
  output logic [`MCU_BUS_W-1:0]             wr_addr_o,
  output logic [`MCU_BUS_W-1:0]             wr_xfer_size_o,
  output logic                              wr_start_o,
  input  logic                              wr_done_i,
  output logic [`MCU_BUS_W-1:0]             wr_tdata_o,
  output logic                              wr_tvalid_o,
  input  logic                              wr_tready_i,
  // Lanes
  input  logic [`MCU_LANES*`MCU_BUS_W-1:0]  lane_st_data_i,
  input  logic                              lane_st_valid_i,
  output logic                              lane_st_ready_o,
  output logic [`MCU_LANES*`MCU_BUS_W-1:0]  lane_ld_data_o,
  output logic [`MCU_LANES-1:0]             lane_ld_mask_o,
  output logic                              lane_ld_valid_o,
  output logic                              lane_ld_last_o,
  input  logic                              lane_ld_ready_i
);
  import mcu_pkg::*;

  logic                 ld_start;
  logic                 st_start;
  logic                 ld_done;
  logic                 st_done;
  sew_e                 sew;
  logic [`MCU_VL_W-1:0] vl;

  mcu_ctrl u_ctrl (
    .clk             (clk),
    .ctrl_rstart     (ctrl_rstart),
    .cmd_req_i       (cmd_req_i),
    .cmd_store_i     (cmd_store_i),
    .cmd_sew_i       (cmd_sew_i),
    .cmd_vl_i        (cmd_vl_i),
    .cmd_base_addr_i (cmd_base_addr_i),
    .rd_done_i       (rd_done_i),
    .wr_done_i       (wr_done_i),
    .ld_done_i       (ld_done),
    .st_done_i       (st_done),
    .cmd_ack_o       (cmd_ack_o),
    .rd_addr_o       (rd_addr_o),
    .rd_xfer_size_o  (rd_xfer_size_o),
    .rd_start_o      (rd_start_o),
    .wr_addr_o       (wr_addr_o),
    .wr_xfer_size_o  (wr_xfer_size_o),
    .wr_start_o      (wr_start_o),
    .ld_start_o      (ld_start),
    .st_start_o      (st_start),
    .sew_o           (sew),
    .vl_o            (vl)
  );

  mcu_load_path u_load_path (
    .clk             (clk),
    .ctrl_rstart     (ctrl_rstart),
    .ld_start_i      (ld_start),
    .sew_i           (sew),
    .vl_i            (vl),
    .rd_tdata_i      (rd_tdata_i),
    .rd_tvalid_i     (rd_tvalid_i),
    .rd_tlast_i      (rd_tlast_i),
    .lane_ld_ready_i (lane_ld_ready_i),
    .ld_done_o       (ld_done),
    .rd_tready_o     (rd_tready_o),
    .lane_ld_data_o  (lane_ld_data_o),
    .lane_ld_mask_o  (lane_ld_mask_o),
    .lane_ld_valid_o (lane_ld_valid_o),
    .lane_ld_last_o  (lane_ld_last_o)
  );

  mcu_store_path u_store_path (
    .clk             (clk),
    .ctrl_rstart     (ctrl_rstart),
    .st_start_i      (st_start),
    .sew_i           (sew),
    .vl_i            (vl),
    .lane_st_data_i  (lane_st_data_i),
    .lane_st_valid_i (lane_st_valid_i),
    .wr_tready_i     (wr_tready_i),
    .st_done_o       (st_done),
    .lane_st_ready_o (lane_st_ready_o),
    .wr_tdata_o      (wr_tdata_o),
    .wr_tvalid_o     (wr_tvalid_o)
  );

endmodule

/* mem_subsys_tb.sv */
// Testbench for the vector memory subsystem with scheduler driver,
// AXI control and memory models, lane models and checks

`timescale 1ns/1ns
`include "mcu_macros.svh"

module mem_subsys_tb;
  import mcu_pkg::*;

  localparam int NUM_PAT  = 15;
  localparam int PAT_COLS = 5;
  localparam int TIMEOUT  = 4000;
  localparam int LW       = `MCU_BUS_W;

  logic                             clk;
  logic                             ctrl_rstart;
  logic                             cmd_req;
  logic                             cmd_store;
  sew_e                             cmd_sew;
  logic [`MCU_VL_W-1:0]             cmd_vl;
  logic [LW-1:0]                    cmd_base_addr;
  logic                             cmd_ack;
  logic [LW-1:0]                    rd_addr;
  logic [LW-1:0]                    rd_xfer_size;
  logic                             rd_start;
  logic                             rd_done;
  logic [LW-1:0]                    rd_tdata;
  logic                             rd_tvalid;
  logic                             rd_tlast;
  logic                             rd_tready;
  logic [LW-1:0]                    wr_addr;
  logic [LW-1:0]                    wr_xfer_size;
  logic                             wr_start;
  logic                             wr_done;
  logic [LW-1:0]                    wr_tdata;
  logic                             wr_tvalid;
  logic                             wr_tready;
  logic [`MCU_LANES*LW-1:0]         lane_st_data;
  logic                             lane_st_valid;
  logic                             lane_st_ready;
  logic [`MCU_LANES*LW-1:0]         lane_ld_data;
  logic [`MCU_LANES-1:0]            lane_ld_mask;
  logic                             lane_ld_valid;
  logic                             lane_ld_last;
  logic                             lane_ld_ready;

  // Pattern table with five columns per command
  logic [31:0] pat_mem [NUM_PAT*PAT_COLS];
  integer      seed;
  string       test_name;
  bit          gaps_on;
  bit          timed_out;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;

  // Current command
  bit          cur_store;
  sew_e        cur_sew;
  int          cur_vl;
  logic [31:0] cur_base;
  logic [31:0] exp_size;
  int          exp_words;
  int          exp_groups;

  // Model state
  int          rd_starts;
  int          wr_starts;
  int          rd_idx;
  int          ld_groups;
  int          wr_words;
  int          st_sent;
  bit          rd_active;
  bit          st_active;
  bit          rd_done_sent;
  bit          wr_done_sent;
  bit          rd_fired;
  bit          st_fired;
  bit          ack_seen;
  bit          ack_low_seen;
  bit          req_dropped;

  mem_subsys u_dut (
    .clk             (clk),
    .ctrl_rstart     (ctrl_rstart),
    .cmd_req_i       (cmd_req),
    .cmd_store_i     (cmd_store),
    .cmd_sew_i       (cmd_sew),
    .cmd_vl_i        (cmd_vl),
    .cmd_base_addr_i (cmd_base_addr),
    .cmd_ack_o       (cmd_ack),
    .rd_addr_o       (rd_addr),
    .rd_xfer_size_o  (rd_xfer_size),
    .rd_start_o      (rd_start),
    .rd_done_i       (rd_done),
    .rd_tdata_i      (rd_tdata),
    .rd_tvalid_i     (rd_tvalid),
    .rd_tlast_i      (rd_tlast),
    .rd_tready_o     (rd_tready),
    .wr_addr_o       (wr_addr),
    .wr_xfer_size_o  (wr_xfer_size),
    .wr_start_o      (wr_start),
    .wr_done_i       (wr_done),
    .wr_tdata_o      (wr_tdata),
    .wr_tvalid_o     (wr_tvalid),
    .wr_tready_i     (wr_tready),
    .lane_st_data_i  (lane_st_data),
    .lane_st_valid_i (lane_st_valid),
    .lane_st_ready_o (lane_st_ready),
    .lane_ld_data_o  (lane_ld_data),
    .lane_ld_mask_o  (lane_ld_mask),
    .lane_ld_valid_o (lane_ld_valid),
    .lane_ld_last_o  (lane_ld_last),
    .lane_ld_ready_i (lane_ld_ready)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////////////////////////
  function automatic int elem_bytes(input sew_e sew);
    case (sew)
      SEW8:    return 1;
      SEW16:   return 2;
      default: return 4;
    endcase
  endfunction

  // Memory contents follow the low address byte
  function automatic logic [7:0] mem_byte(input logic [31:0] addr);
    return addr[7:0] ^ 8'h5a;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] w;
    for (int j = 0; j < 4; j++) begin
      w[8*j +: 8] = mem_byte(addr + 32'(j));
    end
    return w;
  endfunction

  // Load element e in little endian order from the base address
  function automatic logic [31:0] load_elem(input int e);
    logic [31:0] v;
    int          nb;
    nb = elem_bytes(cur_sew);
    v  = '0;
    for (int j = 0; j < nb; j++) begin
      v[8*j +: 8] = mem_byte(cur_base + 32'(e * nb + j));
    end
    return v;
  endfunction

  // Lanes past vl carry junk that must never reach the bus
  function automatic logic [31:0] lane_value(input int e);
    if (e < cur_vl) begin
      return 32'(e * 3 + 1);
    end
    return 32'hdead_0000 | 32'(e);
  endfunction

  function automatic logic [31:0] store_word(input int w);
    logic [31:0] v;
    logic [31:0] el;
    int          nb;
    int          i;
    int          e;
    nb = elem_bytes(cur_sew);
    v  = '0;
    for (int j = 0; j < 4; j++) begin
      i = 4 * w + j;
      e = i / nb;
      if (e < cur_vl) begin
        el          = lane_value(e);
        v[8*j +: 8] = el[8*(i % nb) +: 8];
      end
    end
    return v;
  endfunction

  function automatic bit stall_now();
    if (!gaps_on) begin
      return 1'b0;
    end
    return ($random(seed) & 3) < 2;
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////
  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("%s: %s", test_name, what);
      test_errs++;
    end
  endtask

  task automatic report_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %0d %s: pass", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAIL, %0d errors", tests_run, test_name, test_errs);
    end
  endtask

  // Output sampling at the falling edge
  task automatic sample_outputs();
    logic [31:0]           exp_data;
    logic [`MCU_LANES-1:0] exp_mask;
    int                    e;
    rd_fired = 1'b0;
    st_fired = 1'b0;
    if (rd_start) begin
      rd_starts++;
      rd_active = 1'b1;
      check_value("rd_addr_o", cur_base, rd_addr);
      check_value("rd_xfer_size_o", exp_size, rd_xfer_size);
    end
    if (wr_start) begin
      wr_starts++;
      st_active = 1'b1;
      check_value("wr_addr_o", cur_base, wr_addr);
      check_value("wr_xfer_size_o", exp_size, wr_xfer_size);
    end
    if (rd_tvalid && rd_tready) begin
      rd_fired = 1'b1;
      rd_idx++;
    end
    if (lane_ld_valid && lane_ld_ready) begin
      check_true(ld_groups < exp_groups, "lane load group beyond vl");
      for (int k = 0; k < `MCU_LANES; k++) begin
        e           = 4 * ld_groups + k;
        exp_mask[k] = e < cur_vl;
        exp_data    = (e < cur_vl) ? load_elem(e) : '0;
        check_value($sformatf("group %0d lane %0d", ld_groups, k), exp_data,
                    lane_ld_data[k*LW +: LW]);
      end
      check_value($sformatf("group %0d mask", ld_groups), exp_mask, lane_ld_mask);
      check_value($sformatf("group %0d last", ld_groups),
                  ld_groups == exp_groups - 1, lane_ld_last);
      ld_groups++;
    end
    if (lane_st_valid && lane_st_ready) begin
      st_fired = 1'b1;
      st_sent++;
    end
    if (wr_tvalid && wr_tready) begin
      check_true(wr_words < exp_words, "write word beyond the burst size");
      check_value($sformatf("write word %0d", wr_words), store_word(wr_words), wr_tdata);
      wr_words++;
    end
    // Ack needs both the burst done and the last lane transfer
    if (cmd_ack && !ack_seen) begin
      ack_seen = 1'b1;
      if (cur_store) begin
        check_true(wr_done_sent && wr_words == exp_words,
                   "cmd_ack_o rose before the store burst finished");
      end else begin
        check_true(rd_done_sent && ld_groups == exp_groups,
                   "cmd_ack_o rose before the load burst finished");
      end
    end
    if (ack_seen && !req_dropped) begin
      check_true(cmd_ack, "cmd_ack_o fell while cmd_req_i was still high");
    end
    if (req_dropped && !cmd_ack) begin
      ack_low_seen = 1'b1;
    end
  endtask

  // AXI side and lane models driven on the rising edge
  task automatic drive_inputs();
    if (rd_active && (!rd_tvalid || rd_fired)) begin
      if (rd_idx < exp_words && !stall_now()) begin
        rd_tvalid <= 1'b1;
        rd_tdata  <= mem_word(cur_base + 32'(4 * rd_idx));
        rd_tlast  <= rd_idx == exp_words - 1;
      end else begin
        rd_tvalid <= 1'b0;
        rd_tlast  <= 1'b0;
      end
    end
    // Burst done may lag the last beat when gaps are on
    rd_done <= 1'b0;
    if (rd_active && rd_idx == exp_words && !rd_done_sent && !stall_now()) begin
      rd_done      <= 1'b1;
      rd_done_sent = 1'b1;
      rd_active    = 1'b0;
    end
    lane_ld_ready <= !stall_now();
    wr_tready     <= !stall_now();
    wr_done       <= 1'b0;
    if (wr_starts > 0 && wr_words == exp_words && !wr_done_sent && !stall_now()) begin
      wr_done      <= 1'b1;
      wr_done_sent = 1'b1;
    end
    if (st_active && (!lane_st_valid || st_fired)) begin
      if (st_sent < exp_groups && !stall_now()) begin
        lane_st_valid <= 1'b1;
        for (int k = 0; k < `MCU_LANES; k++) begin
          lane_st_data[k*LW +: LW] <= lane_value(4 * st_sent + k);
        end
      end else begin
        lane_st_valid <= 1'b0;
      end
    end
  endtask

  task automatic step();
    @(negedge clk);
    sample_outputs();
    @(posedge clk);
    drive_inputs();
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////
  task automatic check_reset_quiet();
    test_name = "reset quiet";
    test_errs = 0;
    repeat (4) begin
      @(negedge clk);
      check_value("control outputs", '0, {cmd_ack, rd_start, wr_start, rd_tready,
                                          wr_tvalid, lane_st_ready, lane_ld_valid});
      @(posedge clk);
    end
    report_test();
  endtask

  task automatic run_test(input int p);
    int cnt;
    cur_store  = pat_mem[p*PAT_COLS][0];
    cur_sew    = sew_e'(pat_mem[p*PAT_COLS+1][1:0]);
    cur_vl     = int'(pat_mem[p*PAT_COLS+2]);
    cur_base   = pat_mem[p*PAT_COLS+3];
    exp_size   = pat_mem[p*PAT_COLS+4];
    exp_words  = int'(exp_size) / 4;
    exp_groups = (cur_vl + 3) / 4;
    test_name  = $sformatf("%s sew%0d vl %0d%s", cur_store ? "store" : "load",
                           8 * elem_bytes(cur_sew), cur_vl, gaps_on ? " gaps" : "");
    test_errs    = 0;
    rd_starts    = 0;
    wr_starts    = 0;
    rd_idx       = 0;
    ld_groups    = 0;
    wr_words     = 0;
    st_sent      = 0;
    rd_active    = 1'b0;
    st_active    = 1'b0;
    rd_done_sent = 1'b0;
    wr_done_sent = 1'b0;
    ack_seen     = 1'b0;
    ack_low_seen = 1'b0;
    req_dropped  = 1'b0;
    // Scheduler raises the command
    cmd_store     <= cur_store;
    cmd_sew       <= cur_sew;
    cmd_vl        <= `MCU_VL_W'(cur_vl);
    cmd_base_addr <= cur_base;
    cmd_req       <= 1'b1;
    cnt = 0;
    while (!ack_seen && cnt < TIMEOUT) begin
      step();
      cnt++;
    end
    if (!ack_seen) begin
      $display("%s: timed out waiting for cmd_ack_o to rise", test_name);
      test_errs++;
      timed_out = 1'b1;
    end else begin
      // Ack must hold while the request stays up
      repeat (2) step();
      cmd_req     <= 1'b0;
      req_dropped = 1'b1;
      cnt = 0;
      while (!ack_low_seen && cnt < TIMEOUT) begin
        step();
        cnt++;
      end
      if (!ack_low_seen) begin
        $display("%s: timed out waiting for cmd_ack_o to fall", test_name);
        test_errs++;
        timed_out = 1'b1;
      end
    end
    check_value("rd_start_o pulses", cur_store ? 0 : 1, rd_starts);
    check_value("wr_start_o pulses", cur_store ? 1 : 0, wr_starts);
    report_test();
  endtask

  initial begin
    seed          = 32'h4b3a;
    clk           = 1'b0;
    ctrl_rstart   = 1'b1;
    cmd_req       = 1'b0;
    cmd_store     = 1'b0;
    cmd_sew       = SEW8;
    cmd_vl        = '0;
    cmd_base_addr = '0;
    rd_done       = 1'b0;
    rd_tdata      = '0;
    rd_tvalid     = 1'b0;
    rd_tlast      = 1'b0;
    wr_done       = 1'b0;
    wr_tready     = 1'b0;
    lane_st_data  = '0;
    lane_st_valid = 1'b0;
    lane_ld_ready = 1'b0;
    timed_out     = 1'b0;
    total_errs    = 0;
    tests_run     = 0;
    tests_failed  = 0;
    $readmemh("mcu_patterns.hex", pat_mem);
    repeat (16) @(posedge clk);
    ctrl_rstart <= 1'b0;
    check_reset_quiet();
    // Second pass adds random back-pressure
    for (int pass = 0; pass < 2 && !timed_out; pass++) begin
      gaps_on = pass == 1;
      for (int p = 0; p < NUM_PAT && !timed_out; p++) begin
        run_test(p);
      end
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, total_errs);
    if (total_errs == 0 && !timed_out) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+.
mcu_pkg.sv
mcu_ctrl.sv
mcu_load_path.sv
mcu_store_path.sv
mem_subsys.sv
mem_subsys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module mem_subsys_tb -o mem_subsys_sim \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/mem_subsys_sim > sim.log 2>&1 ; cat sim.log

! grep -q "ERRORS FOUND" sim.log && grep -q "NO ERRORS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
